// ==== adp_debug_ctrl.f ====
rtl/adp_defs_pkg.sv
rtl/ahb_defs_pkg.sv
rtl/adp_param_builder.sv
rtl/adp_ahb_master.sv
rtl/adp_hex_writer.sv
rtl/adp_monitor_fsm.sv
rtl/adp_debug_ctrl.sv
sim/tb_adp_debug_ctrl.sv

// ==== rtl/adp_ahb_master.sv ====
// --------------------
// AHB-lite single transfer master
// owns the address pointer and advances it per transfer
// --------------------
`timescale 1ns/1ps

module adp_ahb_master (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  req_i,
  input  logic                  write_i,
  input  ahb_defs_pkg::hsize_e  size_i,
  input  logic                  addr_load_i,
  input  logic [31:0]           addr_i,
  input  logic [31:0]           wdata_i,
  output logic [31:0]           addr_o,
  output logic                  done_o,
  output logic                  err_o,
  output logic [31:0]           rdata_o,
  output logic [31:0]           HADDR_o,
  output ahb_defs_pkg::htrans_e HTRANS_o,
  output ahb_defs_pkg::hsize_e  HSIZE_o,
  output logic [2:0]            HBURST_o,
  output logic [3:0]            HPROT_o,
  output logic                  HWRITE_o,
  output logic [31:0]           HWDATA_o,
  output logic                  HMASTLOCK_o,
  input  logic [31:0]           HRDATA_i,
  input  logic                  HREADY_i,
  input  logic                  HRESP_i
);
  import ahb_defs_pkg::*;

  logic       dphase_q;
  hsize_e     size_q;  // size of the transfer in data phase
  logic [1:0] lane;
  logic [1:0] lane_q;

  always_comb begin
    case (size_i)
      HSIZE_BYTE: lane = addr_o[1:0];
      HSIZE_HALF: lane = {addr_o[1], 1'b0};
      default:    lane = 2'b00;
    endcase
  end

  // --------------------
  // address phase
  assign HADDR_o     = {addr_o[31:2], lane};
  assign HTRANS_o    = req_i ? HTRANS_NONSEQ : HTRANS_IDLE;
  assign HSIZE_o     = size_i;
  assign HWRITE_o    = req_i & write_i;
  assign HBURST_o    = AHB_HBURST_INCR;
  assign HPROT_o     = AHB_HPROT_DATA;
  assign HMASTLOCK_o = 1'b0;

  // --------------------
  // data phase
  assign done_o = dphase_q & HREADY_i;
  assign err_o  = dphase_q & HRESP_i;

  always_comb begin
    case (size_q)
      HSIZE_BYTE: HWDATA_o = {4{wdata_i[7:0]}};
      HSIZE_HALF: HWDATA_o = {2{wdata_i[15:0]}};
      default:    HWDATA_o = wdata_i;
    endcase
    case (lane_q) // addressed lane down to bit 0
      2'd1:    rdata_o = {HRDATA_i[7:0], HRDATA_i[31:8]};
      2'd2:    rdata_o = {HRDATA_i[15:0], HRDATA_i[31:16]};
      2'd3:    rdata_o = {HRDATA_i[23:0], HRDATA_i[31:24]};
      default: rdata_o = HRDATA_i;
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      dphase_q <= 1'b0;
      addr_o   <= '0;
    end else begin
      if (HREADY_i) begin
        dphase_q <= req_i;
      end
      if (addr_load_i) begin
        addr_o <= addr_i;
      end else if (done_o) begin
        addr_o <= addr_o + (32'd1 << size_q); // step by transfer size
      end
    end
  end

  always_ff @(posedge HCLK) begin
    if (req_i) begin
      size_q <= size_i;
      lane_q <= lane;
    end
  end

endmodule

// ==== rtl/adp_debug_ctrl.sv ====
// --------------------
// ASCII debug monitor top level
// byte stream commands to AHB-lite transfers and GPIO
// --------------------
`timescale 1ns/1ps

module adp_debug_ctrl #(
  parameter logic [7:0]  PROMPT_CHAR = "]",
  parameter logic [31:0] BANNER_WORD = 32'h0adb0001
) (
  input  logic        HCLK,
  input  logic        HRESETn,
  output logic [31:0] HADDR_o,
  output logic [1:0]  HTRANS_o,
  output logic [2:0]  HSIZE_o,
  output logic [2:0]  HBURST_o,
  output logic [3:0]  HPROT_o,
  output logic        HWRITE_o,
  output logic [31:0] HWDATA_o,
  output logic        HMASTLOCK_o,
  input  logic [31:0] HRDATA_i,
  input  logic        HREADY_i,
  input  logic        HRESP_i,
  output logic [7:0]  GPO_o,
  input  logic [7:0]  GPI_i,
  input  logic [7:0]  COMRX_TDATA_i,
  input  logic        COMRX_TVALID_i,
  output logic        COMRX_TREADY_o,
  output logic [7:0]  COMTX_TDATA_o,
  output logic        COMTX_TVALID_o,
  input  logic        COMTX_TREADY_i
);
  import adp_defs_pkg::*;
  import ahb_defs_pkg::*;

  logic        fsm_tx_valid;
  logic [7:0]  fsm_tx_byte;
  logic        hex_tx_valid;
  logic [7:0]  hex_tx_byte;
  logic        hex_busy;
  logic        hex_start;
  logic [31:0] hex_word;
  hsize_e      hex_size;
  logic        hex_err;
  logic        param_clear;
  logic        param_load;
  logic [31:0] param;
  adp_psize_t  psize;
  logic        bus_req;
  logic        bus_write;
  hsize_e      bus_size;
  logic        addr_load;
  logic [31:0] addr;
  logic        bus_done;
  logic        bus_err;
  logic [31:0] bus_rdata;

  // hex writer owns TX while busy
  assign COMTX_TVALID_o = hex_busy ? hex_tx_valid : fsm_tx_valid;
  assign COMTX_TDATA_o  = hex_busy ? hex_tx_byte : fsm_tx_byte;

  adp_monitor_fsm #(
    .PROMPT_CHAR (PROMPT_CHAR),
    .BANNER_WORD (BANNER_WORD)
  ) u_fsm (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .rx_valid_i    (COMRX_TVALID_i),
    .rx_byte_i     (COMRX_TDATA_i),
    .rx_ready_o    (COMRX_TREADY_o),
    .tx_ready_i    (COMTX_TREADY_i),
    .tx_valid_o    (fsm_tx_valid),
    .tx_byte_o     (fsm_tx_byte),
    .hex_start_o   (hex_start),
    .hex_word_o    (hex_word),
    .hex_size_o    (hex_size),
    .hex_err_o     (hex_err),
    .hex_busy_i    (hex_busy),
    .param_clear_o (param_clear),
    .param_load_o  (param_load),
    .param_i       (param),
    .psize_i       (psize),
    .bus_req_o     (bus_req),
    .bus_write_o   (bus_write),
    .bus_size_o    (bus_size),
    .addr_load_o   (addr_load),
    .addr_i        (addr),
    .bus_done_i    (bus_done),
    .bus_err_i     (bus_err),
    .bus_rdata_i   (bus_rdata),
    .GPI_i         (GPI_i),
    .GPO_o         (GPO_o)
  );

  adp_param_builder u_param (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .clear_i (param_clear),
    .byte_i  (COMRX_TDATA_i),
    .load_i  (param_load),
    .param_o (param),
    .psize_o (psize)
  );

  adp_hex_writer u_hex (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .start_i    (hex_start),
    .word_i     (hex_word),
    .size_i     (hex_size),
    .err_i      (hex_err),
    .tx_ready_i (COMTX_TREADY_i),
    .tx_valid_o (hex_tx_valid),
    .tx_byte_o  (hex_tx_byte),
    .busy_o     (hex_busy)
  );

  adp_ahb_master u_ahb (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .req_i       (bus_req),
    .write_i     (bus_write),
    .size_i      (bus_size),
    .addr_load_i (addr_load),
    .addr_i      (param),    // A loads the parsed value
    .wdata_i     (param),
    .addr_o      (addr),
    .done_o      (bus_done),
    .err_o       (bus_err),
    .rdata_o     (bus_rdata),
    .HADDR_o     (HADDR_o),
    .HTRANS_o    (HTRANS_o),
    .HSIZE_o     (HSIZE_o),
    .HBURST_o    (HBURST_o),
    .HPROT_o     (HPROT_o),
    .HWRITE_o    (HWRITE_o),
    .HWDATA_o    (HWDATA_o),
    .HMASTLOCK_o (HMASTLOCK_o),
    .HRDATA_i    (HRDATA_i),
    .HREADY_i    (HREADY_i),
    .HRESP_i     (HRESP_i)
  );

endmodule

// ==== rtl/adp_defs_pkg.sv ====
// --------------------
// debug monitor protocol definitions
// command codes, FSM states, characters, parameter sizes
// --------------------
package adp_defs_pkg;

  typedef enum logic [3:0] {
    CMD_NONE = 4'd0,
    CMD_A    = 4'd1, // address set or query
    CMD_C    = 4'd2, // GPIO control
    CMD_R    = 4'd3, // read, then advance
    CMD_W    = 4'd4, // write, then advance
    CMD_X    = 4'd5  // leave monitor mode
  } adp_cmd_e;

  typedef enum logic [4:0] {
    ST_BANNER,
    ST_HEXWAIT,
    ST_LF,
    ST_CR,
    ST_PROMPT,
    ST_IDLE,
    ST_RXCMD,
    ST_RXPARAM,
    ST_ACTION,
    ST_BUS,
    ST_ECHO,
    ST_UNKNOWN,
    ST_EXIT
  } adp_state_e;

  // digit count class of the parameter
  typedef logic [1:0] adp_psize_t;
  localparam adp_psize_t PSIZE_NONE = 2'd0;
  localparam adp_psize_t PSIZE_BYTE = 2'd1;
  localparam adp_psize_t PSIZE_HALF = 2'd2;
  localparam adp_psize_t PSIZE_WORD = 2'd3;

  localparam logic [7:0] CHAR_EOT   = 8'h04;
  localparam logic [7:0] CHAR_TAB   = 8'h09;
  localparam logic [7:0] CHAR_LF    = 8'h0a;
  localparam logic [7:0] CHAR_CR    = 8'h0d;
  localparam logic [7:0] CHAR_ESC   = 8'h1b;
  localparam logic [7:0] CHAR_SPACE = 8'h20;
  localparam logic [7:0] CHAR_BANG  = 8'h21;
  localparam logic [7:0] CHAR_QUERY = 8'h3f;

  // C command sub-ops in parameter bits 31:8
  localparam logic [23:0] GPO_OP_CLEAR = 24'h000001;
  localparam logic [23:0] GPO_OP_SET   = 24'h000002;
  localparam logic [23:0] GPO_OP_WRITE = 24'h000003;

endpackage

// ==== rtl/adp_hex_writer.sv ====
// --------------------
// hex field writer
// sends separator, 0x prefix and 2, 4 or 8 hex digits
// --------------------
`timescale 1ns/1ps

module adp_hex_writer (
  input  logic                 HCLK,
  input  logic                 HRESETn,
  input  logic                 start_i,
  input  logic [31:0]          word_i,
  input  ahb_defs_pkg::hsize_e size_i,
  input  logic                 err_i,
  input  logic                 tx_ready_i,
  output logic                 tx_valid_o,
  output logic [7:0]           tx_byte_o,
  output logic                 busy_o
);
  import adp_defs_pkg::*;
  import ahb_defs_pkg::*;

  logic [3:0]  idx_q;  // 0 separator, 1 and 2 prefix, then digits
  logic [3:0]  last_q;
  logic [31:0] word_q; // next digit always in the top nibble
  logic        err_q;
  logic [3:0]  nibble;
  logic        tx_done;

  assign nibble     = word_q[31:28];
  assign tx_valid_o = busy_o;
  assign tx_done    = tx_valid_o & tx_ready_i;

  always_comb begin
    case (idx_q)
      4'd0:    tx_byte_o = err_q ? CHAR_BANG : CHAR_SPACE;
      4'd1:    tx_byte_o = "0";
      4'd2:    tx_byte_o = "x";
      default: tx_byte_o = (nibble < 4'd10) ? 8'h30 + {4'h0, nibble}
                                            : 8'h57 + {4'h0, nibble}; // lower case a-f
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      busy_o <= 1'b0;
      idx_q  <= '0;
    end else if (start_i) begin
      busy_o <= 1'b1;
      idx_q  <= '0;
    end else if (tx_done) begin
      busy_o <= (idx_q != last_q);
      idx_q  <= idx_q + 4'd1;
    end
  end

  always_ff @(posedge HCLK) begin
    if (start_i) begin
      err_q <= err_i;
      case (size_i)
        HSIZE_BYTE: begin
          word_q <= {word_i[7:0], 24'h0};
          last_q <= 4'd4;
        end
        HSIZE_HALF: begin
          word_q <= {word_i[15:0], 16'h0};
          last_q <= 4'd6;
        end
        default: begin
          word_q <= word_i;
          last_q <= 4'd10;
        end
      endcase
    end else if (tx_done && idx_q >= 4'd3) begin
      word_q <= {word_q[27:0], 4'h0};
    end
  end

endmodule

// ==== rtl/adp_monitor_fsm.sv ====
// --------------------
// debug monitor command FSM
// banner, ESC entry, line parsing, actions and echo
// --------------------
`timescale 1ns/1ps

module adp_monitor_fsm #(
  parameter logic [7:0]  PROMPT_CHAR = "]",
  parameter logic [31:0] BANNER_WORD = 32'h0adb0001
) (
  input  logic                     HCLK,
  input  logic                     HRESETn,
  input  logic                     rx_valid_i,
  input  logic [7:0]               rx_byte_i,
  output logic                     rx_ready_o,
  input  logic                     tx_ready_i,
  output logic                     tx_valid_o,
  output logic [7:0]               tx_byte_o,
  output logic                     hex_start_o,
  output logic [31:0]              hex_word_o,
  output ahb_defs_pkg::hsize_e     hex_size_o,
  output logic                     hex_err_o,
  input  logic                     hex_busy_i,
  output logic                     param_clear_o,
  output logic                     param_load_o,
  input  logic [31:0]              param_i,
  input  adp_defs_pkg::adp_psize_t psize_i,
  output logic                     bus_req_o,
  output logic                     bus_write_o,
  output ahb_defs_pkg::hsize_e     bus_size_o,
  output logic                     addr_load_o,
  input  logic [31:0]              addr_i,
  input  logic                     bus_done_i,
  input  logic                     bus_err_i,
  input  logic [31:0]              bus_rdata_i,
  input  logic [7:0]               GPI_i,
  output logic [7:0]               GPO_o
);
  import adp_defs_pkg::*;
  import ahb_defs_pkg::*;

  adp_state_e state;
  adp_cmd_e   cmd_q;
  logic [7:0] letter_q; // upper-case command letter for echo
  logic       banner_q;
  logic       err_q;    // sticky bus error
  hsize_e     size_q;
  logic [7:0] gpo_next;
  logic       rx_done;
  logic       tx_done;
  logic       rx_exit;
  logic       rx_eol;
  logic       rx_blank;

  function automatic adp_cmd_e decode_cmd(input logic [7:0] ch);
    case (ch)
      "A", "a": decode_cmd = CMD_A;
      "C", "c": decode_cmd = CMD_C;
      "R", "r": decode_cmd = CMD_R;
      "W", "w": decode_cmd = CMD_W;
      "X", "x": decode_cmd = CMD_X;
      default:  decode_cmd = CMD_NONE;
    endcase
  endfunction

  function automatic hsize_e to_hsize(input adp_psize_t p);
    case (p)
      PSIZE_BYTE: to_hsize = HSIZE_BYTE;
      PSIZE_HALF: to_hsize = HSIZE_HALF;
      default:    to_hsize = HSIZE_WORD; // no digits means word
    endcase
  endfunction

  task automatic send(input logic [7:0] ch, input adp_state_e nxt);
    tx_valid_o <= 1'b1;
    tx_byte_o  <= ch;
    state      <= nxt;
  endtask

  assign rx_done  = rx_valid_i & rx_ready_o;
  assign tx_done  = tx_valid_o & tx_ready_i;
  assign rx_exit  = (rx_byte_i == CHAR_EOT) || (rx_byte_i == 8'h00);
  assign rx_eol   = (rx_byte_i == CHAR_CR) || (rx_byte_i == CHAR_LF);
  assign rx_blank = (rx_byte_i == CHAR_SPACE) || (rx_byte_i == CHAR_TAB);

  assign rx_ready_o    = state inside {ST_IDLE, ST_RXCMD, ST_RXPARAM};
  assign param_clear_o = (state == ST_RXCMD) && rx_done && !rx_exit && !rx_eol && !rx_blank;
  assign param_load_o  = (state == ST_RXPARAM) && rx_done;
  assign hex_size_o    = size_q;
  assign bus_size_o    = size_q;
  assign hex_err_o     = err_q;

  always_comb begin
    case (param_i[31:8])
      GPO_OP_CLEAR: gpo_next = GPO_o & ~param_i[7:0];
      GPO_OP_SET:   gpo_next = GPO_o | param_i[7:0];
      GPO_OP_WRITE: gpo_next = param_i[7:0];
      default:      gpo_next = GPO_o; // report only
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state       <= ST_BANNER;
      cmd_q       <= CMD_NONE;
      letter_q    <= '0;
      banner_q    <= 1'b1;
      err_q       <= 1'b0;
      size_q      <= HSIZE_WORD;
      tx_valid_o  <= 1'b0;
      tx_byte_o   <= '0;
      hex_start_o <= 1'b0;
      hex_word_o  <= '0;
      bus_req_o   <= 1'b0;
      bus_write_o <= 1'b0;
      addr_load_o <= 1'b0;
      GPO_o       <= '0;
    end else begin
      hex_start_o <= 1'b0; // pulses
      bus_req_o   <= 1'b0;
      addr_load_o <= 1'b0;
      if (tx_done) begin
        tx_valid_o <= 1'b0;
      end
      case (state)
        ST_BANNER: begin
          hex_word_o  <= BANNER_WORD;
          size_q      <= HSIZE_WORD;
          hex_start_o <= 1'b1;
          state       <= ST_HEXWAIT;
        end
        ST_HEXWAIT: if (!hex_start_o && !hex_busy_i) begin
          err_q <= 1'b0;
          send(CHAR_LF, ST_LF);
        end
        ST_LF: if (tx_done) send(CHAR_CR, ST_CR);
        ST_CR: if (tx_done) begin
          if (banner_q) begin
            banner_q <= 1'b0;
            state    <= ST_IDLE;
          end else begin
            send(PROMPT_CHAR, ST_PROMPT);
          end
        end
        ST_PROMPT: if (tx_done) state <= ST_RXCMD;
        ST_IDLE: if (rx_done && rx_byte_i == CHAR_ESC) send(CHAR_LF, ST_LF);
        ST_RXCMD: if (rx_done) begin
          if (rx_exit) begin
            state <= ST_IDLE;
          end else if (rx_eol) begin
            send(CHAR_LF, ST_LF); // empty line, fresh prompt
          end else if (!rx_blank) begin
            cmd_q    <= decode_cmd(rx_byte_i);
            letter_q <= rx_byte_i & 8'h5f;
            state    <= ST_RXPARAM;
          end
        end
        ST_RXPARAM: if (rx_done) begin
          if (rx_exit) begin
            state <= ST_IDLE;
          end else if (rx_eol) begin
            state <= ST_ACTION;
          end
        end
        ST_ACTION: begin
          size_q <= HSIZE_WORD;
          case (cmd_q)
            CMD_A: begin
              addr_load_o <= (psize_i != PSIZE_NONE);
              hex_word_o  <= (psize_i != PSIZE_NONE) ? param_i : addr_i;
              send(letter_q, ST_ECHO);
            end
            CMD_C: begin
              GPO_o      <= gpo_next;
              hex_word_o <= {GPI_i, gpo_next, param_i[15:0]};
              send(letter_q, ST_ECHO);
            end
            CMD_R, CMD_W: begin
              size_q      <= to_hsize(psize_i);
              bus_req_o   <= 1'b1;
              bus_write_o <= (cmd_q == CMD_W);
              hex_word_o  <= param_i; // write echo value
              state       <= ST_BUS;
            end
            CMD_X:   send(CHAR_LF, ST_EXIT);
            default: send(CHAR_QUERY, ST_UNKNOWN);
          endcase
        end
        ST_BUS: if (bus_done_i) begin
          err_q <= err_q | bus_err_i;
          if (!bus_write_o) begin
            hex_word_o <= bus_rdata_i;
          end
          send(letter_q, ST_ECHO);
        end
        ST_ECHO: if (tx_done) begin
          hex_start_o <= 1'b1;
          state       <= ST_HEXWAIT;
        end
        ST_UNKNOWN: if (tx_done) send(CHAR_LF, ST_LF);
        ST_EXIT:    if (tx_done) state <= ST_IDLE;
        default:    state <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== rtl/adp_param_builder.sv ====
// --------------------
// command parameter builder
// shifts in hex digits and classifies the digit count
// --------------------
`timescale 1ns/1ps

module adp_param_builder (
  input  logic                     HCLK,
  input  logic                     HRESETn,
  input  logic                     clear_i,
  input  logic [7:0]               byte_i,
  input  logic                     load_i,
  output logic [31:0]              param_o,
  output adp_defs_pkg::adp_psize_t psize_o
);
  import adp_defs_pkg::*;

  logic [2:0] digit_cnt; // saturates at 5
  logic [3:0] nibble;
  logic       is_hex;
  logic       is_sep;

  always_comb begin
    is_hex = 1'b1;
    nibble = byte_i[3:0];
    if ((byte_i >= "a" && byte_i <= "f") || (byte_i >= "A" && byte_i <= "F")) begin
      nibble = byte_i[3:0] + 4'd9; // letters start at low nibble 1
    end else if (byte_i < "0" || byte_i > "9") begin
      is_hex = 1'b0;
    end
  end

  assign is_sep = (byte_i == CHAR_SPACE) || (byte_i == CHAR_TAB) ||
                  (byte_i == "x") || (byte_i == "X");

  assign psize_o = (digit_cnt == 3'd0) ? PSIZE_NONE :
                   (digit_cnt <  3'd3) ? PSIZE_BYTE :
                   (digit_cnt <  3'd5) ? PSIZE_HALF : PSIZE_WORD;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      param_o   <= '0;
      digit_cnt <= '0;
    end else if (clear_i || (load_i && is_sep)) begin
      param_o   <= '0; // new parameter
      digit_cnt <= '0;
    end else if (load_i && is_hex) begin
      param_o <= {param_o[27:0], nibble};
      if (digit_cnt != 3'd5) begin
        digit_cnt <= digit_cnt + 3'd1;
      end
    end
  end

endmodule

// ==== rtl/ahb_defs_pkg.sv ====
// --------------------
// AHB-lite encodings used by the monitor bus master
// --------------------
package ahb_defs_pkg;

  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_NONSEQ = 2'b10
  } htrans_e;

  typedef enum logic [2:0] {
    HSIZE_BYTE = 3'b000,
    HSIZE_HALF = 3'b001,
    HSIZE_WORD = 3'b010
  } hsize_e;

  localparam logic [2:0] AHB_HBURST_INCR = 3'b001;
  localparam logic [3:0] AHB_HPROT_DATA  = 4'b0011; // privileged data access

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# build and run the debug monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f adp_debug_ctrl.f --top-module tb_adp_debug_ctrl \
  -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/Vtb_adp_debug_ctrl > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
exit 0

// ==== sim/tb_adp_debug_ctrl.sv ====
// --------------------
// testbench for the ASCII debug monitor
// AHB memory model, COM stream driver, reply reference and checks
// --------------------
`timescale 1ns/1ps

module tb_adp_debug_ctrl;
  import adp_defs_pkg::*;
  import ahb_defs_pkg::*;

  localparam logic [7:0]  PROMPT = "]";
  localparam logic [31:0] BANNER = 32'h0adb0001;
  localparam logic [7:0]  GPI_VAL = 8'h3c;

  logic        HCLK;
  logic        HRESETn;
  logic [31:0] HADDR_o;
  logic [1:0]  HTRANS_o;
  logic [2:0]  HSIZE_o;
  logic [2:0]  HBURST_o;
  logic [3:0]  HPROT_o;
  logic        HWRITE_o;
  logic [31:0] HWDATA_o;
  logic        HMASTLOCK_o;
  logic [31:0] HRDATA_i;
  logic        HREADY_i;
  logic        HRESP_i;
  logic [7:0]  GPO_o;
  logic [7:0]  GPI_i;
  logic [7:0]  COMRX_TDATA_i;
  logic        COMRX_TVALID_i;
  logic        COMRX_TREADY_o;
  logic [7:0]  COMTX_TDATA_o;
  logic        COMTX_TVALID_o;
  logic        COMTX_TREADY_i;

  integer      seed = 67;
  integer      error_count = 0;
  logic [31:0] mem [0:1023];    // bus-side memory
  logic [31:0] shadow [0:1023]; // reference copy
  logic [31:0] addr_ref;
  logic [7:0]  gpo_ref;

  adp_debug_ctrl #(.PROMPT_CHAR(PROMPT), .BANNER_WORD(BANNER)) UUT (.*);

  initial begin
    HCLK = 1'b0;
    forever #20 HCLK = ~HCLK;
  end

  function automatic logic [31:0] fill_word(input int idx);
    fill_word = (idx * 32'h01000193) ^ 32'h5a5a0000;
  endfunction

  function automatic logic in_err_window(input logic [31:0] a);
    in_err_window = (a >= 32'h2000) && (a <= 32'h20ff);
  endfunction

  // --------------------
  // AHB memory model with random wait states
  logic        m_dph;
  logic        m_write;
  logic        m_err;
  logic [31:0] m_addr;
  hsize_e      m_size;
  integer      m_wait;

  initial begin
    int lane;
    m_dph = 1'b0;
    forever begin
      @(posedge HCLK);
      if (m_dph && HREADY_i) begin
        m_dph = 1'b0;
        lane  = int'(m_addr[1:0]);
        if (m_write && !m_err) begin
          case (m_size)
            HSIZE_BYTE: mem[m_addr[11:2]][lane*8 +: 8] = HWDATA_o[lane*8 +: 8];
            HSIZE_HALF: mem[m_addr[11:2]][lane*8 +: 16] = HWDATA_o[lane*8 +: 16];
            default:    mem[m_addr[11:2]] = HWDATA_o;
          endcase
        end
      end
      if (HREADY_i && HTRANS_o == 2'b10) begin
        check_ctrl("HBURST_o", {1'b0, HBURST_o}, 4'b0001); // INCR
        check_ctrl("HPROT_o", HPROT_o, 4'b0011);          // privileged data
        check_ctrl("HMASTLOCK_o", {3'b000, HMASTLOCK_o}, 4'b0000);
        m_dph   = 1'b1;
        m_addr  = HADDR_o;
        m_size  = hsize_e'(HSIZE_o);
        m_write = HWRITE_o;
        m_err   = in_err_window(HADDR_o);
        m_wait  = $random(seed) & 3;
      end
      #1;
      if (m_dph && m_wait > 0) begin
        m_wait   = m_wait - 1;
        HREADY_i = 1'b0;
      end else begin
        HREADY_i = 1'b1;
        HRESP_i  = m_dph && m_err;
        HRDATA_i = (m_dph && !m_err) ? mem[m_addr[11:2]] : 32'h0;
      end
    end
  end

  // --------------------
  // failure handling and compare tasks
  task automatic stop_run(input string why);
    error_count = error_count + 1;
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_str(input string name, input string got, input string exp);
    if (got != exp) begin
      stop_run($sformatf("Fail at %0t: %s got \"%s\" expected \"%s\"", $time, name, got, exp));
    end
  endtask

  task automatic check_gpo(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("Fail at %0t: GPO_o got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic check_cmd(input adp_cmd_e got, input adp_cmd_e exp);
    if (got !== exp) begin
      stop_run($sformatf("Fail at %0t: cmd_q got %s expected %s", $time, got.name(), exp.name()));
    end
  endtask

  task automatic check_ctrl(input string name, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("Fail at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  // --------------------
  // COM stream driver and collector
  task automatic send_byte(input logic [7:0] b);
    int t;
    t = 0;
    COMRX_TDATA_i  = b;
    COMRX_TVALID_i = 1'b1;
    do begin
      @(posedge HCLK);
      t = t + 1;
      if (t > 2000) stop_run("timeout: DUT never accepted an RX byte");
    end while (!COMRX_TREADY_o);
    #1;
    COMRX_TVALID_i = 1'b0;
  endtask

  task automatic send_line(input string s);
    for (int i = 0; i < s.len(); i++) send_byte(s[i]);
  endtask

  task automatic recv_bytes(input int n, output string s);
    int t;
    s = "";
    for (int i = 0; i < n; i++) begin
      t = 0;
      forever begin
        @(posedge HCLK);
        if (COMTX_TVALID_o && COMTX_TREADY_i) break;
        t = t + 1;
        if (t > 2000) stop_run("timeout: DUT sent too few TX bytes");
        #1;
        COMTX_TREADY_i = ($random(seed) & 3) != 0; // random stalls
      end
      s = {s, $sformatf("%c", COMTX_TDATA_o)};
      #1;
      COMTX_TREADY_i = ($random(seed) & 3) != 0;
    end
    COMTX_TREADY_i = 1'b0;
  endtask

  task automatic expect_quiet(input int cycles);
    COMTX_TREADY_i = 1'b1;
    for (int i = 0; i < cycles; i++) begin
      @(posedge HCLK);
      if (COMTX_TVALID_o) stop_run("DUT sent a TX byte while it should stay silent");
    end
    #1;
    COMTX_TREADY_i = 1'b0;
  endtask

  // --------------------
  // reference model of the replies
  function automatic string hex_digits(input logic [31:0] v, input int n);
    string s;
    logic [3:0] nb;
    s = "";
    for (int i = n - 1; i >= 0; i--) begin
      nb = v[i*4 +: 4];
      s  = {s, $sformatf("%h", nb)};
    end
    return s;
  endfunction

  function automatic int size_bytes(input int ndig);
    if (ndig == 0 || ndig > 4) return 4;
    if (ndig <= 2) return 1;
    return 2;
  endfunction

  function automatic adp_cmd_e letter_cmd(input logic [7:0] c);
    case (c)
      "A": return CMD_A;
      "C": return CMD_C;
      "R": return CMD_R;
      "W": return CMD_W;
      "X": return CMD_X;
      default: return CMD_NONE;
    endcase
  endfunction

  function automatic string expected_reply(input logic [7:0] c, input logic [31:0] p,
                                           input int ndig);
    logic [31:0] value;
    logic        err;
    int          nb;
    int          lane;
    err   = 1'b0;
    value = 32'h0;
    nb    = 4;
    case (c)
      "A": begin
        if (ndig > 0) addr_ref = p;
        value = addr_ref;
      end
      "C": begin
        case (p[31:8])
          24'd1: gpo_ref = gpo_ref & ~p[7:0];
          24'd2: gpo_ref = gpo_ref | p[7:0];
          24'd3: gpo_ref = p[7:0];
          default: gpo_ref = gpo_ref;
        endcase
        value = {GPI_VAL, gpo_ref, p[15:0]};
      end
      "R", "W": begin
        nb   = size_bytes(ndig);
        lane = (nb == 1) ? int'(addr_ref[1:0]) : (nb == 2) ? int'(addr_ref[1]) * 2 : 0;
        err  = in_err_window(addr_ref);
        if (c == "W") begin
          value = p;
          if (!err) begin
            case (nb)
              1: shadow[addr_ref[11:2]][lane*8 +: 8] = p[7:0];
              2: shadow[addr_ref[11:2]][lane*8 +: 16] = p[15:0];
              default: shadow[addr_ref[11:2]] = p;
            endcase
          end
        end else begin
          value = err ? 32'h0 : shadow[addr_ref[11:2]] >> (lane * 8);
        end
        addr_ref = addr_ref + nb;
      end
      "X": return "\n";
      default: return $sformatf("?\n\r%c", PROMPT);
    endcase
    return $sformatf("%c%s0x%s\n\r%c", c, err ? "!" : " ", hex_digits(value, nb * 2), PROMPT);
  endfunction

  task automatic run_cmd(input logic [7:0] c, input logic [31:0] p, input int ndig);
    string exp;
    string got;
    exp = expected_reply(c, p, ndig);
    if (ndig == 0) send_line($sformatf("%c\r", c));
    else send_line($sformatf("%c %s\r", c, hex_digits(p, ndig)));
    recv_bytes(exp.len(), got);
    check_str("COMTX_TDATA_o", got, exp);
    check_cmd(adp_cmd_e'(UUT.u_fsm.cmd_q), letter_cmd(c));
  endtask

  // --------------------
  // test sequence
  initial begin
    string got;
    HRESETn        = 1'b0;
    HRDATA_i       = 32'h0;
    HREADY_i       = 1'b1;
    HRESP_i        = 1'b0;
    GPI_i          = GPI_VAL;
    COMRX_TDATA_i  = 8'h00;
    COMRX_TVALID_i = 1'b0;
    COMTX_TREADY_i = 1'b0;
    addr_ref       = 32'h0;
    gpo_ref        = 8'h00;
    for (int i = 0; i < 1024; i++) begin
      mem[i]    = fill_word(i);
      shadow[i] = fill_word(i);
    end
    repeat (10) @(posedge HCLK);
    #1;
    HRESETn = 1'b1;

    recv_bytes(13, got);
    check_str("COMTX_TDATA_o", got, {" 0x", hex_digits(BANNER, 8), "\n\r"});
    check_gpo(GPO_o, 8'h00);
    send_line("hello A\r");
    expect_quiet(60);
    send_byte(CHAR_ESC);
    recv_bytes(3, got);
    check_str("COMTX_TDATA_o", got, $sformatf("\n\r%c", PROMPT));

    run_cmd("A", 32'h1000, 4);
    run_cmd("A", 32'h0, 0);
    run_cmd("W", 32'h12345678, 8);
    run_cmd("W", 32'habcd, 4);
    run_cmd("W", 32'h5a, 2);
    run_cmd("W", 32'hc3, 2);
    run_cmd("A", 32'h0, 0);
    run_cmd("A", 32'h1000, 4);
    run_cmd("R", 32'h0, 0);
    run_cmd("R", 32'h0, 4);
    run_cmd("R", 32'h0, 4);
    run_cmd("A", 32'h1005, 4);
    run_cmd("R", 32'h0, 2);
    run_cmd("R", 32'h0, 2);
    run_cmd("R", 32'h0, 2);
    run_cmd("A", 32'h0, 0);

    run_cmd("C", 32'h3a5, 3);
    check_gpo(GPO_o, gpo_ref);
    run_cmd("C", 32'h10f, 3);
    check_gpo(GPO_o, gpo_ref);
    run_cmd("C", 32'h2f0, 3);
    check_gpo(GPO_o, gpo_ref);
    run_cmd("C", 32'h0, 0);
    check_gpo(GPO_o, gpo_ref);

    run_cmd("A", 32'h2000, 4);
    run_cmd("R", 32'h0, 0);
    run_cmd("W", 32'h11, 2);
    run_cmd("A", 32'h0, 0);

    run_cmd("Q", 32'h0, 0);
    run_cmd("X", 32'h0, 0);
    send_line("A\r");
    expect_quiet(60);
    send_byte(CHAR_ESC);
    recv_bytes(3, got);
    check_str("COMTX_TDATA_o", got, $sformatf("\n\r%c", PROMPT));
    run_cmd("A", 32'h0, 0);

    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
